// File: files.f
src/procPkg.sv
src/fetchStage.sv
src/regFile.sv
src/pipeCtrl.sv
src/executeStage.sv
src/memStage.sv
src/proc.sv
verif/procTb.sv

// File: verif/procTb.sv
`timescale 1ns/1ps
`default_nettype none

module procTb;
    import procPkg::*;

    localparam int IMEM_AW = 8;
    localparam int DMEM_AW = 8;

    logic                clk;
    logic                rstN;
    logic                progWe;
    logic [IMEM_AW-1:0]  progAddr;
    logic [DATA_W-1:0]   progData;
    logic                wbValid;
    logic [REG_AW-1:0]   wbAddr;
    logic [DATA_W-1:0]   wbData;
    logic                halted;
    logic                err;

    logic [DATA_W-1:0]   prog [2**IMEM_AW];                    // Program image for load and model
    int                  progLen;
    logic [31:0]         rngState;
    logic [REG_AW-1:0]   expReg [$];                           // Expected retirements, in order
    logic [DATA_W-1:0]   expVal [$];
    int                  expIdx;
    logic                expErr;
    logic                errSeen;                              // err went high this run
    logic                checking;

    proc #(.imemAddrW(IMEM_AW), .dmemAddrW(DMEM_AW)) proc_inst (
        .clk(clk), .rstN(rstN),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData),
        .halted(halted), .err(err)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                                 // 8 ns period
    end

    task automatic failRun(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic checkReg(input string name, input logic [REG_AW-1:0] got,
                            input logic [REG_AW-1:0] exp);
        if (got !== exp) begin
            failRun($sformatf("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp));
        end
    endtask

    task automatic checkData(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            failRun($sformatf("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp));
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            failRun($sformatf("Mismatch at %0t: %s got %0b expected %0b", $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Instruction encoders, field order straight from the ISA formats
    function automatic logic [DATA_W-1:0] rInstr(input logic [1:0] fn, input logic [2:0] rd,
                                                 input logic [2:0] rs, input logic [2:0] rt);
        return {OP_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic logic [DATA_W-1:0] iInstr(input logic [4:0] op, input logic [2:0] rd,
                                                 input logic [2:0] rs, input logic [4:0] imm);
        return {op, rs, rd, imm};
    endfunction

    function automatic logic [DATA_W-1:0] bInstr(input logic [4:0] op, input logic [2:0] rs,
                                                 input logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    function automatic void noteWrite(input logic [REG_AW-1:0] r, input logic [DATA_W-1:0] v);
        expReg.push_back(r);
        expVal.push_back(v);
    endfunction

    // Unpipelined ISA interpreter, returns the expected error level
    function automatic logic isaModel();
        logic [DATA_W-1:0] rf [8];
        logic [DATA_W-1:0] dm [2**DMEM_AW];
        logic [DATA_W-1:0] pc;
        logic [DATA_W-1:0] w;
        logic [DATA_W-1:0] s5;
        logic [DATA_W-1:0] s8;
        logic [DATA_W-1:0] res;
        logic [DATA_W-1:0] ea;
        logic              errOut;
        logic              done;
        int                steps;
        for (int i = 0; i < 8; i++) begin
            rf[i] = '0;                                        // Cleared by reset
        end
        pc = '0;
        errOut = 1'b0;
        done = 1'b0;
        steps = 0;
        expReg.delete();
        expVal.delete();
        while (!done && steps < 1000) begin
            w = prog[pc[IMEM_AW-1:0]];
            s5 = {{11{w[4]}}, w[4:0]};
            s8 = {{8{w[7]}}, w[7:0]};
            ea = rf[w[10:8]] + s5;                             // LD/ST address
            pc = pc + 1'b1;
            steps++;
            case (w[15:11])
                OP_HALT: done = 1'b1;
                OP_NOP:  ;
                OP_ADDI: begin
                    rf[w[7:5]] = rf[w[10:8]] + s5;
                    noteWrite(w[7:5], rf[w[7:5]]);
                end
                OP_LBI: begin
                    rf[w[10:8]] = s8;                          // Target in rs slot
                    noteWrite(w[10:8], s8);
                end
                OP_LD: begin
                    rf[w[7:5]] = dm[ea[DMEM_AW-1:0]];
                    noteWrite(w[7:5], rf[w[7:5]]);
                end
                OP_ST: dm[ea[DMEM_AW-1:0]] = rf[w[7:5]];
                OP_BEQZ: begin
                    if (rf[w[10:8]] == '0) begin
                        pc = pc + s8;                          // pc already holds PC+1
                    end
                end
                OP_RTYPE: begin
                    case (w[1:0])
                        FN_ADD:  res = rf[w[10:8]] + rf[w[7:5]];
                        FN_SUB:  res = rf[w[10:8]] - rf[w[7:5]];
                        FN_AND:  res = rf[w[10:8]] & rf[w[7:5]];
                        default: res = rf[w[10:8]] ^ rf[w[7:5]];
                    endcase
                    rf[w[4:2]] = res;
                    noteWrite(w[4:2], res);
                end
                default: errOut = 1'b1;                        // Illegal acts as NOP
            endcase
        end
        return errOut;
    endfunction

    task automatic buildMainProgram();
        logic [7:0] immA;
        logic [7:0] immB;
        logic [4:0] immC;
        logic [4:0] immD;
        rngState = xorshift32(rngState);
        immA = rngState[7:0];
        rngState = xorshift32(rngState);
        immB = rngState[15:8] | 8'h80;                         // Force negative
        rngState = xorshift32(rngState);
        immC = rngState[4:0];
        rngState = xorshift32(rngState);
        immD = rngState[12:8] | 5'h10;                         // Force negative
        prog[0]  = bInstr(OP_LBI, 3'd1, immA);
        prog[1]  = bInstr(OP_LBI, 3'd2, immB);
        prog[2]  = rInstr(FN_ADD, 3'd3, 3'd1, 3'd2);           // Dependent R chain
        prog[3]  = rInstr(FN_SUB, 3'd4, 3'd3, 3'd1);
        prog[4]  = rInstr(FN_AND, 3'd5, 3'd4, 3'd2);
        prog[5]  = rInstr(FN_XOR, 3'd6, 3'd5, 3'd3);
        prog[6]  = iInstr(OP_ADDI, 3'd7, 3'd6, immC);
        prog[7]  = iInstr(OP_ADDI, 3'd1, 3'd1, immD);
        prog[8]  = bInstr(OP_LBI, 3'd2, 8'h10);                // Base address
        prog[9]  = iInstr(OP_ST, 3'd7, 3'd2, 5'd1);
        prog[10] = iInstr(OP_ST, 3'd3, 3'd2, 5'h1f);           // Offset -1
        prog[11] = iInstr(OP_LD, 3'd4, 3'd2, 5'd1);
        prog[12] = rInstr(FN_ADD, 3'd5, 3'd4, 3'd4);           // Load-use stall
        prog[13] = iInstr(OP_LD, 3'd6, 3'd2, 5'h1f);
        prog[14] = bInstr(OP_LBI, 3'd0, 8'h00);
        prog[15] = bInstr(OP_BEQZ, 3'd0, 8'd2);                // Taken, to 18
        prog[16] = bInstr(OP_LBI, 3'd5, 8'h55);                // Wrong path
        prog[17] = bInstr(OP_LBI, 3'd5, 8'h66);
        prog[18] = bInstr(OP_BEQZ, 3'd2, 8'd1);                // Not taken
        prog[19] = bInstr(OP_LBI, 3'd3, 8'hfd);
        prog[20] = iInstr(OP_ADDI, 3'd3, 3'd3, 5'd1);
        prog[21] = {OP_HALT, 11'd0};
        progLen = 22;
    endtask

    task automatic buildIllegalProgram();
        prog[0] = bInstr(OP_LBI, 3'd1, 8'd5);
        prog[1] = {5'b11111, 11'd0};                           // Unused opcode
        prog[2] = iInstr(OP_ADDI, 3'd2, 3'd1, 5'd3);
        prog[3] = {OP_HALT, 11'd0};
        progLen = 4;
    endtask

    task automatic waitForHalt(input int limit);
        int n;
        n = 0;
        while (!halted) begin
            if (n >= limit) begin
                failRun("Timeout: halted never rose");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic waitForErr(input int limit);
        int n;
        n = 0;
        while (!err) begin
            if (n >= limit) begin
                failRun("Timeout: err never rose");
            end
            @(negedge clk);
            n++;
        end
    endtask

    // Load under reset, run to HALT, then watch a quiet window
    task automatic runProgram();
        checking = 1'b0;
        expErr = isaModel();
        expIdx = 0;
        errSeen = 1'b0;
        @(posedge clk);
        rstN <= 1'b0;
        for (int i = 0; i < progLen; i++) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= i[IMEM_AW-1:0];
            progData <= prog[i];
        end
        @(posedge clk);
        progWe <= 1'b0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        checking = 1'b1;
        if (expErr) begin
            waitForErr(400);
        end
        waitForHalt(400);
        repeat (10) @(negedge clk);                            // No retirements after halt
        if (expIdx != expReg.size()) begin
            failRun("Fewer retirements than the reference model expects");
        end
        checkFlag("halted", halted, 1'b1);
        checkFlag("err", err, expErr);
        checking = 1'b0;
    endtask

    // Retirement checker, outputs settle well before the falling edge
    always @(negedge clk) begin
        if (checking) begin
            if (wbValid && halted) begin
                failRun("Register write retired after halted rose");
            end else if (wbValid && expIdx >= expReg.size()) begin
                failRun("More retirements than the reference model expects");
            end else if (wbValid) begin
                checkReg("wbAddr", wbAddr, expReg[expIdx]);
                checkData("wbData", wbData, expVal[expIdx]);
                expIdx++;
            end
            if (!expErr || errSeen) begin
                checkFlag("err", err, errSeen);                // Low, or sticky once set
            end
            if (err) begin
                errSeen = 1'b1;
            end
        end
    end

    initial begin
        rstN     <= 1'b0;
        progWe   <= 1'b0;
        progAddr <= '0;
        progData <= '0;
        checking = 1'b0;
        rngState = 32'h343f_0987;
        buildMainProgram();
        runProgram();
        buildIllegalProgram();                                 // Second run, fresh reset
        runProgram();
        $display("TB PASSED");
        $finish;
    end
endmodule

`default_nettype wire

// File: src/proc.sv
`timescale 1ns/1ps
`default_nettype none

module proc #(
    parameter int imemAddrW = 8,
    parameter int dmemAddrW = 8
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       progWe,
    input  logic [imemAddrW-1:0]       progAddr,
    input  logic [procPkg::DATA_W-1:0] progData,
    output logic                       wbValid,
    output logic [procPkg::REG_AW-1:0] wbAddr,
    output logic [procPkg::DATA_W-1:0] wbData,
    output logic                       halted,
    output logic                       err
);
    import procPkg::*;

    logic [DATA_W-1:0] idInstr;                                // IF/ID
    logic [DATA_W-1:0] idPc;
    logic              stall;                                  // Control to fetch
    logic              flush;
    logic              fetchStop;
    logic              branchTaken;
    logic [DATA_W-1:0] branchTarget;
    logic [REG_AW-1:0] rdAddrA;                                // Register file reads
    logic [REG_AW-1:0] rdAddrB;
    logic [DATA_W-1:0] rdDataA;
    logic [DATA_W-1:0] rdDataB;
    logic              idRegWrite;                             // Decoded levels
    logic [REG_AW-1:0] idDest;
    logic              idMemRead;
    logic              idMemWrite;
    logic              idUseImm;
    logic              idHalt;
    logic [REG_AW-1:0] exDest;                                 // ID/EX feedback
    logic              exRegWrite;
    logic [DATA_W-1:0] memAddrOrResult;                        // EX/MEM
    logic [DATA_W-1:0] memStoreData;
    logic              memRead;
    logic              memWrite;
    logic              memRegWrite;
    logic [REG_AW-1:0] memDest;
    logic              memHalt;

    fetchStage #(.imemAddrW(imemAddrW)) fetchInst (
        .clk(clk), .rstN(rstN),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .stall(stall), .flush(flush), .fetchStop(fetchStop),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .idInstr(idInstr), .idPc(idPc)
    );

    regFile regFileInst (
        .clk(clk), .rstN(rstN),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
        .wrEn(wbValid), .wrAddr(wbAddr), .wrData(wbData),      // Writeback port
        .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    pipeCtrl ctrlInst (
        .clk(clk), .rstN(rstN),
        .idInstr(idInstr), .idPc(idPc), .rsData(rdDataA),
        .exDest(exDest), .exRegWrite(exRegWrite),
        .memDest(memDest), .memRegWrite(memRegWrite), .memHalt(memHalt),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
        .stall(stall), .flush(flush), .fetchStop(fetchStop),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .idRegWrite(idRegWrite), .idDest(idDest),
        .idMemRead(idMemRead), .idMemWrite(idMemWrite),
        .idUseImm(idUseImm), .idHalt(idHalt),
        .halted(halted), .err(err)
    );

    executeStage exInst (
        .clk(clk), .rstN(rstN), .stall(stall),
        .idInstr(idInstr), .rsData(rdDataA), .rtData(rdDataB),
        .idRegWrite(idRegWrite), .idDest(idDest),
        .idMemRead(idMemRead), .idMemWrite(idMemWrite),
        .idUseImm(idUseImm), .idHalt(idHalt),
        .exDest(exDest), .exRegWrite(exRegWrite),
        .memAddrOrResult(memAddrOrResult), .memStoreData(memStoreData),
        .memRead(memRead), .memWrite(memWrite),
        .memRegWrite(memRegWrite), .memDest(memDest), .memHalt(memHalt)
    );

    memStage #(.dmemAddrW(dmemAddrW)) memInst (
        .clk(clk), .rstN(rstN),
        .memAddrOrResult(memAddrOrResult), .memStoreData(memStoreData),
        .memRead(memRead), .memWrite(memWrite),
        .memRegWrite(memRegWrite), .memDest(memDest),
        .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
    );
endmodule

`default_nettype wire

// File: src/memStage.sv
`timescale 1ns/1ps
`default_nettype none

module memStage #(
    parameter int dmemAddrW = 8                                // Depth is 2**dmemAddrW words
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [procPkg::DATA_W-1:0] memAddrOrResult,
    input  logic [procPkg::DATA_W-1:0] memStoreData,
    input  logic                       memRead,
    input  logic                       memWrite,
    input  logic                       memRegWrite,
    input  logic [procPkg::REG_AW-1:0] memDest,
    output logic                       wbValid,                // Retirement strobe
    output logic [procPkg::REG_AW-1:0] wbAddr,
    output logic [procPkg::DATA_W-1:0] wbData
);
    import procPkg::*;

    logic [DATA_W-1:0]    dmem [2**dmemAddrW];
    logic [dmemAddrW-1:0] addr;
    logic [DATA_W-1:0]    loadData;

    assign addr = memAddrOrResult[dmemAddrW-1:0];              // Modulo depth

    always_ff @(posedge clk) begin
        if (memWrite) begin
            dmem[addr] <= memStoreData;
        end
    end

    assign loadData = dmem[addr];                              // Async read

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= memRegWrite;
        end
    end

    always_ff @(posedge clk) begin
        wbAddr <= memDest;
        wbData <= memRead ? loadData : memAddrOrResult;        // LD vs ALU result
    end

    oneMemOp: assert property (@(posedge clk) disable iff (!rstN)
        !(memRead && memWrite))
        else $error("load and store in MEM together");
endmodule

`default_nettype wire

// File: src/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       stall,                  // Inject bubble
    input  procPkg::instrWord          idInstr,
    input  logic [procPkg::DATA_W-1:0] rsData,
    input  logic [procPkg::DATA_W-1:0] rtData,
    input  logic                       idRegWrite,
    input  logic [procPkg::REG_AW-1:0] idDest,
    input  logic                       idMemRead,
    input  logic                       idMemWrite,
    input  logic                       idUseImm,
    input  logic                       idHalt,
    output logic [procPkg::REG_AW-1:0] exDest,
    output logic                       exRegWrite,
    output logic [procPkg::DATA_W-1:0] memAddrOrResult,
    output logic [procPkg::DATA_W-1:0] memStoreData,
    output logic                       memRead,
    output logic                       memWrite,
    output logic                       memRegWrite,
    output logic [procPkg::REG_AW-1:0] memDest,
    output logic                       memHalt
);
    import procPkg::*;

    instrWord          exInstr;
    logic [DATA_W-1:0] exRs;
    logic [DATA_W-1:0] exRt;
    logic              exMemRead;
    logic              exMemWrite;
    logic              exUseImm;
    logic              exHalt;
    logic              isLbi;
    logic [DATA_W-1:0] immExt;
    logic [DATA_W-1:0] opA;
    logic [DATA_W-1:0] opB;
    logic [DATA_W-1:0] aluOut;

    always_ff @(posedge clk) begin
        if (!rstN || stall) begin
            exRegWrite <= 1'b0;                                // Bubble
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exUseImm   <= 1'b0;
            exHalt     <= 1'b0;
        end else begin
            exRegWrite <= idRegWrite;
            exMemRead  <= idMemRead;
            exMemWrite <= idMemWrite;
            exUseImm   <= idUseImm;
            exHalt     <= idHalt;
        end
    end

    always_ff @(posedge clk) begin
        exInstr <= idInstr;
        exRs    <= rsData;
        exRt    <= rtData;
        exDest  <= idDest;
    end

    assign isLbi  = (exInstr.bFmt.opcode == OP_LBI);
    assign immExt = isLbi ? {{(DATA_W-8){exInstr.bFmt.imm[7]}}, exInstr.bFmt.imm}
                          : {{(DATA_W-5){exInstr.iFmt.imm[4]}}, exInstr.iFmt.imm};
    assign opA    = isLbi ? '0 : exRs;                         // LBI adds to zero
    assign opB    = exUseImm ? immExt : exRt;

    always_comb begin
        aluOut = opA + opB;                                    // Address or ADDI sum
        if (exInstr.rFmt.opcode == OP_RTYPE) begin
            case (exInstr.rFmt.funct)
                FN_SUB:  aluOut = opA - opB;
                FN_AND:  aluOut = opA & opB;
                FN_XOR:  aluOut = opA ^ opB;
                default: aluOut = opA + opB;                   // FN_ADD
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            memRead     <= 1'b0;
            memWrite    <= 1'b0;
            memRegWrite <= 1'b0;
            memHalt     <= 1'b0;
        end else begin
            memRead     <= exMemRead;
            memWrite    <= exMemWrite;
            memRegWrite <= exRegWrite;
            memHalt     <= exHalt;
        end
    end

    always_ff @(posedge clk) begin
        memAddrOrResult <= aluOut;
        memStoreData    <= exRt;                               // rd value for ST
        memDest         <= exDest;
    end
endmodule

`default_nettype wire

// File: src/pipeCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module pipeCtrl (
    input  logic                       clk,
    input  logic                       rstN,
    input  procPkg::instrWord          idInstr,
    input  logic [procPkg::DATA_W-1:0] idPc,
    input  logic [procPkg::DATA_W-1:0] rsData,                 // Read port A feeds BEQZ test
    input  logic [procPkg::REG_AW-1:0] exDest,
    input  logic                       exRegWrite,
    input  logic [procPkg::REG_AW-1:0] memDest,
    input  logic                       memRegWrite,
    input  logic                       memHalt,                // HALT in MEM stage
    output logic [procPkg::REG_AW-1:0] rdAddrA,
    output logic [procPkg::REG_AW-1:0] rdAddrB,
    output logic                       stall,
    output logic                       flush,
    output logic                       fetchStop,
    output logic                       branchTaken,
    output logic [procPkg::DATA_W-1:0] branchTarget,
    output logic                       idRegWrite,
    output logic [procPkg::REG_AW-1:0] idDest,
    output logic                       idMemRead,
    output logic                       idMemWrite,
    output logic                       idUseImm,
    output logic                       idHalt,
    output logic                       halted,
    output logic                       err
);
    import procPkg::*;

    logic useA;                                                // ID reads port A
    logic useB;                                                // ID reads port B
    logic isBeqz;
    logic illegal;
    logic stopped;                                             // HALT has passed decode
    logic hazA;
    logic hazB;

    always_comb begin
        idRegWrite = 1'b0;
        idDest     = idInstr.iFmt.rd;
        idMemRead  = 1'b0;
        idMemWrite = 1'b0;
        idUseImm   = 1'b0;
        idHalt     = 1'b0;
        useA       = 1'b0;
        useB       = 1'b0;
        isBeqz     = 1'b0;
        illegal    = 1'b0;
        rdAddrB    = idInstr.rFmt.rt;                          // Also the ST data register
        case (idInstr.rFmt.opcode)
            OP_RTYPE: begin
                idRegWrite = 1'b1;
                idDest     = idInstr.rFmt.rd;
                useA       = 1'b1;
                useB       = 1'b1;
            end
            OP_ADDI: begin
                idRegWrite = 1'b1;
                idUseImm   = 1'b1;
                useA       = 1'b1;
            end
            OP_LBI: begin
                idRegWrite = 1'b1;
                idDest     = idInstr.bFmt.rs;                  // Target sits in rs field
                idUseImm   = 1'b1;
            end
            OP_LD: begin
                idRegWrite = 1'b1;
                idMemRead  = 1'b1;
                idUseImm   = 1'b1;
                useA       = 1'b1;
            end
            OP_ST: begin
                idMemWrite = 1'b1;
                idUseImm   = 1'b1;
                useA       = 1'b1;
                useB       = 1'b1;                             // Store data source
            end
            OP_BEQZ: begin
                isBeqz = 1'b1;
                useA   = 1'b1;
            end
            OP_HALT: idHalt = 1'b1;
            OP_NOP:  ;                                         // Nothing to do
            default: illegal = 1'b1;
        endcase
    end

    assign rdAddrA = idInstr.rFmt.rs;                          // Same slot in every format

    // RAW hazards on EX and MEM writers
    assign hazA = useA && ((exRegWrite && exDest == rdAddrA) ||
                           (memRegWrite && memDest == rdAddrA));
    assign hazB = useB && ((exRegWrite && exDest == rdAddrB) ||
                           (memRegWrite && memDest == rdAddrB));
    assign stall = hazA || hazB;

    assign branchTaken  = isBeqz && !stall && (rsData == '0);  // Only with fresh rs
    assign branchTarget = idPc + 1'b1 +
                          {{(DATA_W-8){idInstr.bFmt.imm[7]}}, idInstr.bFmt.imm};
    assign flush        = branchTaken;
    assign fetchStop    = idHalt || stopped;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stopped <= 1'b0;
            halted  <= 1'b0;
            err     <= 1'b0;
        end else begin
            if (idHalt) begin
                stopped <= 1'b1;
            end
            if (memHalt) begin
                halted <= 1'b1;                                // HALT leaves MEM
            end
            if (illegal) begin
                err <= 1'b1;                                   // Sticky
            end
        end
    end

    quietAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
        halted |-> !idRegWrite)
        else $error("register write decoded after halt");
endmodule

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [procPkg::REG_AW-1:0] rdAddrA,
    input  logic [procPkg::REG_AW-1:0] rdAddrB,
    input  logic                       wrEn,                   // From MEM/WB
    input  logic [procPkg::REG_AW-1:0] wrAddr,
    input  logic [procPkg::DATA_W-1:0] wrData,
    output logic [procPkg::DATA_W-1:0] rdDataA,
    output logic [procPkg::DATA_W-1:0] rdDataB
);
    import procPkg::*;

    logic [DATA_W-1:0] regs [2**REG_AW];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Write-through so decode sees the WB result this cycle
    assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
    assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

    wrAddrKnown: assert property (@(posedge clk) disable iff (!rstN)
        wrEn |-> !$isunknown(wrAddr))
        else $error("regFile write with unknown address");
endmodule

`default_nettype wire

// File: src/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
    parameter int imemAddrW = 8                                // Depth is 2**imemAddrW words
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       progWe,                 // Program load strobe
    input  logic [imemAddrW-1:0]       progAddr,
    input  logic [procPkg::DATA_W-1:0] progData,
    input  logic                       stall,                  // Hold PC and IF/ID
    input  logic                       flush,                  // Squash wrong-path fetch
    input  logic                       fetchStop,              // HALT reached decode
    input  logic                       branchTaken,
    input  logic [procPkg::DATA_W-1:0] branchTarget,
    output logic [procPkg::DATA_W-1:0] idInstr,
    output logic [procPkg::DATA_W-1:0] idPc
);
    import procPkg::*;

    logic [DATA_W-1:0] imem [2**imemAddrW];                    // Instruction store
    logic [DATA_W-1:0] pc;
    logic [DATA_W-1:0] pcNext;
    logic [DATA_W-1:0] ifInstr;

    always_ff @(posedge clk) begin
        if (progWe) begin
            imem[progAddr] <= progData;                        // Loader may write any time
        end
    end

    assign ifInstr = imem[pc[imemAddrW-1:0]];                  // Async read, wraps at depth

    always_comb begin
        if (branchTaken) begin
            pcNext = branchTarget;                             // Redirect from decode
        end else if (stall || fetchStop) begin
            pcNext = pc;                                       // Frozen
        end else begin
            pcNext = pc + 1'b1;                                // Word addressed
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc      <= '0;
            idInstr <= NOP_WORD;
        end else begin
            pc <= pcNext;
            if (flush || fetchStop) begin
                idInstr <= NOP_WORD;                           // Kill the fetched word
            end else if (!stall) begin
                idInstr <= ifInstr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            idPc <= pc;                                        // PC travels with its word
        end
    end
endmodule

`default_nettype wire

// File: src/procPkg.sv
`default_nettype none

package procPkg;
    parameter int DATA_W = 16;                  // Datapath and instruction width
    parameter int REG_AW = 3;                   // Eight general registers

    // Any opcode not listed here is illegal
    parameter logic [4:0] OP_HALT  = 5'b00000;
    parameter logic [4:0] OP_NOP   = 5'b00001;
    parameter logic [4:0] OP_ADDI  = 5'b01000;
    parameter logic [4:0] OP_BEQZ  = 5'b01100;
    parameter logic [4:0] OP_ST    = 5'b10000;
    parameter logic [4:0] OP_LD    = 5'b10001;
    parameter logic [4:0] OP_LBI   = 5'b11000;
    parameter logic [4:0] OP_RTYPE = 5'b11011;

    // R-format function select
    parameter logic [1:0] FN_ADD = 2'b00;
    parameter logic [1:0] FN_SUB = 2'b01;       // rs minus rt
    parameter logic [1:0] FN_XOR = 2'b10;
    parameter logic [1:0] FN_AND = 2'b11;

    parameter logic [DATA_W-1:0] NOP_WORD = {OP_NOP, 11'd0};  // Bubble word

    // One 16-bit word, read as R, I or branch/LBI format
    typedef union packed {
        struct packed {
            logic [4:0]        opcode;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [REG_AW-1:0] rd;
            logic [1:0]        funct;
        } rFmt;
        struct packed {
            logic [4:0]        opcode;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rd;              // Destination, or store source
            logic [4:0]        imm;
        } iFmt;
        struct packed {
            logic [4:0]        opcode;
            logic [REG_AW-1:0] rs;              // Tested reg, or LBI target
            logic [7:0]        imm;
        } bFmt;
    } instrWord;
endpackage

`default_nettype wire
